//--- hw/cp0Pkg.sv
package cp0Pkg;

    localparam int DataWidth = 32;
    localparam int IrqWidth  = 6;

    // MIPS register numbers, used directly as the Wishbone address
    localparam logic [4:0] regBadVAddr = 5'd8;
    localparam logic [4:0] regCount    = 5'd9;
    localparam logic [4:0] regCompare  = 5'd11;
    localparam logic [4:0] regStatus   = 5'd12;
    localparam logic [4:0] regCause    = 5'd13;
    localparam logic [4:0] regEpc      = 5'd14;
    localparam logic [4:0] regPrid     = 5'd15;

    localparam logic [DataWidth-1:0] pridValue    = 32'h0000_4220;
    localparam logic [DataWidth-1:0] compareReset = '1;  // Keeps TI quiet after reset

    // Events committed by the pipeline
    typedef enum logic [3:0] {
        excNone,
        excInterrupt,
        excAddrErrFetch,
        excAddrErrLoad,
        excAddrErrStore,
        excSyscall,
        excBreak,
        excReservedInstr,
        excOverflow,
        excTrap,
        excEret
    } excKind_t;

    typedef enum logic [4:0] {
        codeInt  = 5'd0,
        codeAdEl = 5'd4,
        codeAdEs = 5'd5,
        codeSys  = 5'd8,
        codeBp   = 5'd9,
        codeRi   = 5'd10,
        codeOv   = 5'd12,
        codeTr   = 5'd13
    } excCode_t;

    typedef struct packed {
        excKind_t               kind;
        logic [DataWidth-1:0]   pc;
        logic                   inDelaySlot;
        logic [DataWidth-1:0]   badAddr;     // Data address of a load/store fault
    } excReq_t;

    typedef struct packed {
        logic       enter;        // Any exception except ERET
        logic       eret;
        logic       recordEpc;    // Entry with EXL clear
        excCode_t   code;
        logic       badFromPc;
        logic       badFromData;
    } excCommit_t;

    typedef struct packed {
        logic [8:0]   zero0;
        logic         bev;        // Bit 22
        logic [5:0]   zero1;
        logic [7:0]   im;         // Bits 15..8
        logic [5:0]   zero2;
        logic         exl;
        logic         ie;
    } statusView_t;

    typedef struct packed {
        logic         bd;
        logic         ti;
        logic [13:0]  zero0;
        logic [5:0]   ip72;       // Hardware lines, IP7 shared with the timer
        logic [1:0]   ip10;       // Software interrupts
        logic         zero1;
        excCode_t     excCode;
        logic [1:0]   zero2;
    } causeView_t;

    typedef union packed {
        statusView_t  statusView;
        causeView_t   causeView;
    } cp0Word_u;

    typedef struct packed {
        logic       statusWe;
        logic       causeWe;
        logic       countWe;
        logic       compareWe;
        logic       epcWe;
        cp0Word_u   data;
    } regWrite_t;

endpackage

//--- hw/cp0Control.sv
`timescale 1ns/1ps

module cp0Control import cp0Pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 wbCyc,
    input  logic                 wbStb,
    input  logic                 wbWe,
    input  logic [4:0]           wbAdr,
    input  logic [DataWidth-1:0] wbDatW,
    input  excReq_t              excReq,
    input  logic                 exl,
    input  logic [DataWidth-1:0] countWord,
    input  logic [DataWidth-1:0] compareWord,
    input  logic [DataWidth-1:0] statusWord,
    input  logic [DataWidth-1:0] causeWord,
    input  logic [DataWidth-1:0] epcWord,
    input  logic [DataWidth-1:0] badVAddrWord,
    output logic [DataWidth-1:0] wbDatR,
    output logic                 wbAck,
    output regWrite_t            regWr,
    output excCommit_t           commit
);

    logic request;   // New transfer, ack goes out at the next edge
    logic wrStrobe;

    assign request  = wbCyc && wbStb && !wbAck;
    assign wrStrobe = request && wbWe;

    always_ff @(posedge clk) begin
        if (reset) begin
            wbAck <= 1'b0;
        end else begin
            wbAck <= request;  // Single cycle pulse
        end
    end

    // Enables land on the same edge that raises wbAck
    always_comb begin
        regWr.statusWe  = wrStrobe && (wbAdr == regStatus);
        regWr.causeWe   = wrStrobe && (wbAdr == regCause);
        regWr.countWe   = wrStrobe && (wbAdr == regCount);
        regWr.compareWe = wrStrobe && (wbAdr == regCompare);
        regWr.epcWe     = wrStrobe && (wbAdr == regEpc);
        regWr.data      = wbDatW;
    end

    always_comb begin
        case (wbAdr)
            regStatus:   wbDatR = statusWord;
            regCause:    wbDatR = causeWord;
            regCount:    wbDatR = countWord;
            regCompare:  wbDatR = compareWord;
            regEpc:      wbDatR = epcWord;
            regBadVAddr: wbDatR = badVAddrWord;
            regPrid:     wbDatR = pridValue;
            default:     wbDatR = '0;  // Unimplemented registers
        endcase
    end

    // Commit decode from the pipeline event
    always_comb begin
        commit = '0;
        commit.enter = (excReq.kind != excNone) && (excReq.kind != excEret);
        commit.eret  = (excReq.kind == excEret);
        commit.recordEpc = commit.enter && !exl;  // Nested entry keeps EPC and BD
        case (excReq.kind)
            excAddrErrFetch: begin
                commit.code      = codeAdEl;
                commit.badFromPc = 1'b1;
            end
            excAddrErrLoad: begin
                commit.code        = codeAdEl;
                commit.badFromData = 1'b1;
            end
            excAddrErrStore: begin
                commit.code        = codeAdEs;
                commit.badFromData = 1'b1;
            end
            excSyscall:       commit.code = codeSys;
            excBreak:         commit.code = codeBp;
            excReservedInstr: commit.code = codeRi;
            excOverflow:      commit.code = codeOv;
            excTrap:          commit.code = codeTr;
            default:          commit.code = codeInt;
        endcase
    end

    ackNeedsStb: assert property (@(posedge clk) disable iff (reset)
        $rose(wbAck) |-> $past(wbStb));

    enterEretExclusive: assert property (@(posedge clk) disable iff (reset)
        commit.enter |-> !commit.eret);

endmodule

//--- hw/cp0Timer.sv
`timescale 1ns/1ps

module cp0Timer import cp0Pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  regWrite_t            regWr,
    output logic [DataWidth-1:0] countWord,
    output logic [DataWidth-1:0] compareWord,
    output logic                 timerIrq
);

    logic halfTick;  // Count advances when this is set

    always_ff @(posedge clk) begin
        if (reset) begin
            countWord <= '0;
            halfTick  <= 1'b0;
        end else if (regWr.countWe) begin
            countWord <= regWr.data;
            halfTick  <= 1'b0;  // Divider restarts with the new value
        end else begin
            halfTick <= !halfTick;
            if (halfTick) begin
                countWord <= countWord + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            compareWord <= compareReset;
        end else if (regWr.compareWe) begin
            compareWord <= regWr.data;
        end
    end

    // Sticky until software rewrites Compare
    always_ff @(posedge clk) begin
        if (reset) begin
            timerIrq <= 1'b0;
        end else if (regWr.compareWe) begin
            timerIrq <= 1'b0;
        end else if (countWord == compareWord) begin
            timerIrq <= 1'b1;
        end
    end

    compareClearsTi: assert property (@(posedge clk) disable iff (reset)
        regWr.compareWe |=> !timerIrq);

endmodule

//--- hw/cp0StatusCause.sv
`timescale 1ns/1ps

module cp0StatusCause import cp0Pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  regWrite_t            regWr,
    input  excCommit_t           commit,
    input  logic                 excDelaySlot,
    input  logic [IrqWidth-1:0]  irq,
    input  logic                 timerIrq,
    output logic [DataWidth-1:0] statusWord,
    output logic [DataWidth-1:0] causeWord,
    output logic                 exl,
    output logic                 intPending
);

    logic                   bev;
    logic [7:0]             im;
    logic                   ie;
    logic                   bd;
    logic [IrqWidth-1:0]    ip72;
    logic [1:0]             ip10;
    excCode_t               excCode;
    cp0Word_u               statusRd;
    cp0Word_u               causeRd;

    always_ff @(posedge clk) begin
        if (reset) begin
            bev <= 1'b1;  // Boot vectors
            im  <= '0;
            ie  <= 1'b0;
        end else if (regWr.statusWe) begin
            bev <= regWr.data.statusView.bev;
            im  <= regWr.data.statusView.im;
            ie  <= regWr.data.statusView.ie;
        end
    end

    // Exception entry and ERET take priority over a software write
    always_ff @(posedge clk) begin
        if (reset) begin
            exl <= 1'b0;
        end else if (commit.enter) begin
            exl <= 1'b1;
        end else if (commit.eret) begin
            exl <= 1'b0;
        end else if (regWr.statusWe) begin
            exl <= regWr.data.statusView.exl;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bd      <= 1'b0;
            excCode <= codeInt;
        end else if (commit.enter) begin
            excCode <= commit.code;
            if (commit.recordEpc) begin
                bd <= excDelaySlot;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ip72 <= '0;
            ip10 <= '0;
        end else begin
            ip72 <= irq | {timerIrq, {(IrqWidth-1){1'b0}}};  // Timer shares IP7
            if (regWr.causeWe) begin
                ip10 <= regWr.data.causeView.ip10;
            end
        end
    end

    always_comb begin
        statusRd = '0;
        statusRd.statusView.bev = bev;
        statusRd.statusView.im  = im;
        statusRd.statusView.exl = exl;
        statusRd.statusView.ie  = ie;
        causeRd = '0;
        causeRd.causeView.bd      = bd;
        causeRd.causeView.ti      = timerIrq;
        causeRd.causeView.ip72    = ip72;
        causeRd.causeView.ip10    = ip10;
        causeRd.causeView.excCode = excCode;
    end

    assign statusWord = statusRd;
    assign causeWord  = causeRd;
    assign intPending = ie && !exl && (|({ip72, ip10} & im));

    eretClearsExl: assert property (@(posedge clk) disable iff (reset)
        commit.eret |=> !exl);

endmodule

//--- hw/cp0ExcAddr.sv
`timescale 1ns/1ps

module cp0ExcAddr import cp0Pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  regWrite_t            regWr,
    input  excCommit_t           commit,
    input  logic [DataWidth-1:0] excPc,
    input  logic                 excDelaySlot,
    input  logic [DataWidth-1:0] excBadAddr,
    output logic [DataWidth-1:0] epcWord,
    output logic [DataWidth-1:0] badVAddrWord
);

    logic [DataWidth-1:0] restartPc;

    // Delay slot restarts at the branch
    assign restartPc = excDelaySlot ? excPc - DataWidth'(4) : excPc;

    always_ff @(posedge clk) begin
        if (reset) begin
            epcWord <= '0;
        end else if (commit.recordEpc) begin
            epcWord <= restartPc;
        end else if (regWr.epcWe && !commit.enter && !commit.eret) begin
            epcWord <= regWr.data;  // Dropped when a commit lands on the same edge
        end
    end

    // Read only for software
    always_ff @(posedge clk) begin
        if (commit.badFromPc) begin
            badVAddrWord <= excPc;
        end else if (commit.badFromData) begin
            badVAddrWord <= excBadAddr;
        end
    end

endmodule

//--- hw/cp0Top.sv
`timescale 1ns/1ps

module cp0Top import cp0Pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 wbCyc,
    input  logic                 wbStb,
    input  logic                 wbWe,
    input  logic [4:0]           wbAdr,
    input  logic [DataWidth-1:0] wbDatW,
    output logic [DataWidth-1:0] wbDatR,
    output logic                 wbAck,
    input  excReq_t              excReq,
    input  logic [IrqWidth-1:0]  irq,
    output logic                 intPending,
    output logic                 exl,
    output logic [DataWidth-1:0] epc
);

    regWrite_t              regWr;
    excCommit_t             commit;
    logic [DataWidth-1:0]   countWord;
    logic [DataWidth-1:0]   compareWord;
    logic [DataWidth-1:0]   statusWord;
    logic [DataWidth-1:0]   causeWord;
    logic [DataWidth-1:0]   badVAddrWord;
    logic                   timerIrq;

    cp0Control ctrl0 (
        .clk, .reset, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatW, .excReq, .exl,
        .countWord, .compareWord, .statusWord, .causeWord,
        .epcWord(epc), .badVAddrWord, .wbDatR, .wbAck, .regWr, .commit
    );

    cp0Timer timer0 (.clk, .reset, .regWr, .countWord, .compareWord, .timerIrq);

    cp0StatusCause statCause0 (
        .clk, .reset, .regWr, .commit, .excDelaySlot(excReq.inDelaySlot),
        .irq, .timerIrq, .statusWord, .causeWord, .exl, .intPending
    );

    cp0ExcAddr excAddr0 (
        .clk, .reset, .regWr, .commit, .excPc(excReq.pc),
        .excDelaySlot(excReq.inDelaySlot), .excBadAddr(excReq.badAddr),
        .epcWord(epc), .badVAddrWord
    );

endmodule

//--- verification/cp0Tb.sv
`timescale 1ns/1ps

module cp0Tb import cp0Pkg::*; ();

    typedef enum logic [2:0] {opWrite, opRead, opExc, opIrq, opWait, opInt, opMark, opLap} op_t;

    typedef struct packed {
        op_t          op;
        logic [4:0]   adr;
        logic [31:0]  data;      // Write data, irq lines or wait length
        excKind_t     kind;
        logic         ds;
        logic [31:0]  pc;
        logic [31:0]  bad;
        logic [31:0]  expVal;    // Read value, or intPending in bit 0
        logic [31:0]  mask;
    } row_t;

    localparam int ackLimit = 8;
    localparam logic [31:0] allBits = 32'hFFFF_FFFF;
    localparam logic [31:0] causeCheck = 32'h8000_007C;   // BD and ExcCode
    localparam logic [31:0] timerBits  = 32'h4000_8000;   // TI and IP7

    logic clk = 1'b0;
    logic reset;
    logic wbCyc;
    logic wbStb;
    logic wbWe;
    logic [4:0] wbAdr;
    logic [31:0] wbDatW;
    logic [31:0] wbDatR;
    logic wbAck;
    excReq_t excReq;
    logic [IrqWidth-1:0] irq;
    logic intPending;
    logic exl;
    logic [31:0] epc;

    row_t rows[$];
    logic rowsReady = 1'b0;
    logic [31:0] rngState = 32'd15;
    logic [31:0] countMark;

    cp0Top dut0 (
        .clk, .reset, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatW, .wbDatR, .wbAck,
        .excReq, .irq, .intPending, .exl, .epc
    );

    always #5 clk = ~clk;

    task automatic stopOnError(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    task automatic nextAddr(output logic [31:0] word);
        rngState = xorshift(rngState);
        word = {rngState[31:2], 2'b00};  // Word aligned
    endtask

    function automatic logic [31:0] codeField(input int code);
        return 32'(code) << 2;
    endfunction

    task automatic addRow(input op_t op, input logic [4:0] adr, input logic [31:0] data,
                          input logic [31:0] expVal, input logic [31:0] mask);
        row_t r;
        r = '0;
        r.op = op;
        r.adr = adr;
        r.data = data;
        r.expVal = expVal;
        r.mask = mask;
        rows.push_back(r);
    endtask

    task automatic addExc(input excKind_t kind, input logic ds, input logic [31:0] pc,
                          input logic [31:0] bad);
        row_t r;
        r = '0;
        r.op = opExc;
        r.kind = kind;
        r.ds = ds;
        r.pc = pc;
        r.bad = bad;
        rows.push_back(r);
    endtask

    task automatic buildTable();
        logic [31:0] pcA;
        logic [31:0] pcB;
        logic [31:0] pcC;
        logic [31:0] badA;
        logic [31:0] badB;
        // Reset values
        addRow(opRead, regStatus, 0, 32'h0040_0000, allBits);
        addRow(opRead, regCause, 0, 0, allBits);
        addRow(opRead, regPrid, 0, 32'h0000_4220, allBits);
        addRow(opInt, 0, 0, 0, 0);
        // Writable fields only
        addRow(opWrite, regStatus, allBits, 0, 0);
        addRow(opRead, regStatus, 0, 32'h0040_FF03, allBits);
        addRow(opWrite, regStatus, 32'h0040_0000, 0, 0);
        addRow(opWrite, regCause, allBits, 0, 0);
        addRow(opRead, regCause, 0, 32'h0000_0300, allBits);
        addRow(opWrite, regCause, 0, 0, 0);
        addRow(opWrite, regEpc, 32'hA5A5_0004, 0, 0);
        addRow(opRead, regEpc, 0, 32'hA5A5_0004, allBits);
        addRow(opWrite, regCompare, 32'h1234_5678, 0, 0);
        addRow(opRead, regCompare, 0, 32'h1234_5678, allBits);
        // Entry, nested entry, ERET
        nextAddr(pcA);
        nextAddr(pcB);
        addExc(excSyscall, 1'b0, pcA, 0);
        addRow(opRead, regEpc, 0, pcA, allBits);
        addRow(opRead, regCause, 0, codeField(8), causeCheck);
        addRow(opRead, regStatus, 0, 32'h2, 32'h2);
        addExc(excBreak, 1'b1, pcB, 0);  // EXL still set
        addRow(opRead, regEpc, 0, pcA, allBits);
        addRow(opRead, regCause, 0, codeField(9), causeCheck);
        addExc(excEret, 1'b0, 0, 0);
        addRow(opRead, regStatus, 0, 0, 32'h2);
        addExc(excBreak, 1'b1, pcB, 0);
        addRow(opRead, regEpc, 0, pcB - 32'd4, allBits);
        addRow(opRead, regCause, 0, 32'h8000_0000 | codeField(9), causeCheck);
        addExc(excEret, 1'b0, 0, 0);
        // BadVAddr sources and cause codes
        nextAddr(pcC);
        nextAddr(badA);
        nextAddr(badB);
        addExc(excAddrErrFetch, 1'b0, pcC, badA);
        addRow(opRead, regBadVAddr, 0, pcC, allBits);
        addRow(opRead, regCause, 0, codeField(4), 32'h7C);
        addExc(excEret, 1'b0, 0, 0);
        addExc(excAddrErrLoad, 1'b0, pcA, badA);
        addRow(opRead, regBadVAddr, 0, badA, allBits);
        addRow(opRead, regCause, 0, codeField(4), 32'h7C);
        addExc(excEret, 1'b0, 0, 0);
        addExc(excAddrErrStore, 1'b0, pcB, badB);
        addRow(opRead, regCause, 0, codeField(5), 32'h7C);
        addExc(excEret, 1'b0, 0, 0);
        addExc(excOverflow, 1'b0, pcC, badA);
        addRow(opRead, regBadVAddr, 0, badB, allBits);
        addRow(opRead, regCause, 0, codeField(12), 32'h7C);
        addExc(excEret, 1'b0, 0, 0);
        // Timer, Count 0 reaches Compare 20 after about 40 cycles
        addRow(opWrite, regCount, 0, 0, 0);
        addRow(opWrite, regCompare, 32'd20, 0, 0);
        addRow(opWait, 0, 60, 0, 0);
        addRow(opRead, regCause, 0, timerBits, timerBits);
        addRow(opWrite, regStatus, 32'h0040_8001, 0, 0);
        addRow(opInt, 0, 0, 1, 0);
        addRow(opWrite, regCompare, allBits, 0, 0);
        addRow(opRead, regCause, 0, 0, timerBits);
        addRow(opInt, 0, 0, 0, 0);
        addRow(opMark, regCount, 0, 0, 0);
        addRow(opWait, 0, 10, 0, 0);
        addRow(opLap, regCount, 0, 0, 0);
        // Hardware line 0 lands in IP2
        addRow(opIrq, 0, 1, 0, 0);
        addRow(opRead, regCause, 0, 32'h0000_0400, 32'h0000_0400);
        addRow(opInt, 0, 0, 0, 0);
        addRow(opWrite, regStatus, 32'h0040_0401, 0, 0);
        addRow(opInt, 0, 0, 1, 0);
        addRow(opWrite, regStatus, 32'h0040_0001, 0, 0);
        addRow(opInt, 0, 0, 0, 0);
        addRow(opWrite, regStatus, 32'h0040_0401, 0, 0);
        addExc(excInterrupt, 1'b0, pcA, 0);
        addRow(opInt, 0, 0, 0, 0);  // Masked by EXL
        addExc(excEret, 1'b0, 0, 0);
        addRow(opInt, 0, 0, 1, 0);
        addRow(opIrq, 0, 0, 0, 0);
        addRow(opInt, 0, 0, 0, 0);
    endtask

    // Starts and ends 1 ns after a rising edge
    task automatic busTransfer(input logic write, input logic [4:0] adr, input logic [31:0] data,
                               output logic [31:0] rdata);
        int waited;
        waited = 0;
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = write;
        wbAdr = adr;
        wbDatW = data;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!wbAck && waited < ackLimit);
        if (!wbAck) begin
            stopOnError($sformatf("No Wishbone acknowledge from address %0d", adr));
        end
        rdata = wbDatR;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
    endtask

    task automatic applyRow(input row_t r);
        logic [31:0] got;
        logic [31:0] delta;
        case (r.op)
            opWrite: busTransfer(1'b1, r.adr, r.data, got);
            opRead: begin
                busTransfer(1'b0, r.adr, 0, got);
                assert ((got & r.mask) == (r.expVal & r.mask)) else
                    stopOnError($sformatf(
                        "FAILED at %0t ns: register %0d read %h, expected %h mask %h",
                        $time, r.adr, got, r.expVal, r.mask));
                if (r.adr == regEpc) begin  // EPC port to the pipeline
                    assert ((epc & r.mask) == (r.expVal & r.mask)) else
                        stopOnError($sformatf("FAILED at %0t ns: epc output %h, expected %h",
                                              $time, epc, r.expVal));
                end
                if (r.adr == regStatus && r.mask[1]) begin
                    assert (exl == r.expVal[1]) else
                        stopOnError($sformatf("FAILED at %0t ns: exl output %0b, expected %0b",
                                              $time, exl, r.expVal[1]));
                end
            end
            opExc: begin
                excReq.kind = r.kind;
                excReq.pc = r.pc;
                excReq.inDelaySlot = r.ds;
                excReq.badAddr = r.bad;
                @(posedge clk);
                #1;
                excReq.kind = excNone;
            end
            opIrq: begin
                irq = r.data[IrqWidth-1:0];
                @(posedge clk);
                #1;
            end
            opWait: begin
                repeat (r.data) @(posedge clk);
                #1;
            end
            opInt: assert (intPending == r.expVal[0]) else
                stopOnError($sformatf("FAILED at %0t ns: intPending is %0b, expected %0b",
                                      $time, intPending, r.expVal[0]));
            opMark: busTransfer(1'b0, r.adr, 0, countMark);
            default: begin
                busTransfer(1'b0, r.adr, 0, got);
                delta = got - countMark;
                assert (delta > 0 && delta <= 6) else
                    stopOnError($sformatf("FAILED at %0t ns: Count advanced by %0d over 10 cycles",
                                          $time, delta));
            end
        endcase
    endtask

    initial begin
        longint limitNs;
        wait (rowsReady);
        limitNs = longint'(rows.size()) * 20 * 10 + 1000;  // 20 cycles per row plus margin
        #(limitNs);
        stopOnError("Watchdog timeout, the stimulus table did not complete");
    end

    initial begin
        reset = 1'b1;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbAdr = '0;
        wbDatW = '0;
        excReq = '0;
        excReq.kind = excNone;
        irq = '0;
        buildTable();
        rowsReady = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        foreach (rows[i]) begin
            applyRow(rows[i]);
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- vlog.f
hw/cp0Pkg.sv
hw/cp0Control.sv
hw/cp0Timer.sv
hw/cp0StatusCause.sv
hw/cp0ExcAddr.sv
hw/cp0Top.sv
verification/cp0Tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module cp0Tb -f vlog.f -o Vcp0Tb
./obj_dir/Vcp0Tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    echo "cp0 testbench run passed"
else
    echo "cp0 testbench run failed"
    exit 1
fi
